// ==== filelist.f ====
logic/dzPkg.sv
logic/ucodeDecode.sv
logic/ucodeRom.sv
logic/ucodeSequencer.sv
logic/dzDatapath.sv
logic/apbMaster.sv
logic/dzCore.sv
test/dzCore_checker.sv
test/dzCoreTb.sv

// ==== logic/apbMaster.sv ====
`timescale 1ns/1ps

module apbMaster
(
	input  logic        iClock,
	input  logic        rstN,
	input  logic        memReq,
	input  logic        memWrite,
	input  dzPkg::addrT memAddr,
	input  dzPkg::byteT memWdata,
	output logic        memDone,
	output dzPkg::byteT memRdata,
	output logic        psel,
	output logic        penable,
	output logic        pwrite,
	output dzPkg::addrT paddr,
	output dzPkg::byteT pwdata,
	input  dzPkg::byteT prdata,
	input  logic        pready
);
	import dzPkg::*;

	typedef enum logic [1:0] {apbIdle, apbSetup, apbAccess} apbStateT;

	apbStateT state;
	byteT     rdataQ;

	assign psel     = state != apbIdle;
	assign penable  = state == apbAccess;
	assign memDone  = penable && pready;
	// Read data is usable in the completion cycle itself
	assign memRdata = memDone ? prdata : rdataQ;

	always_ff @(posedge iClock)
	begin
		if (!rstN)
			state <= apbIdle;
		else
		begin
			case (state)
				apbIdle:   state <= memReq ? apbSetup : apbIdle;
				apbSetup:  state <= apbAccess;
				apbAccess: state <= pready ? apbIdle : apbAccess;
				default:   state <= apbIdle;
			endcase
		end
	end

	// Request is latched once, so the bus stays stable through the transfer
	always_ff @(posedge iClock)
	begin
		if (state == apbIdle && memReq)
		begin
			paddr  <= memAddr;
			pwrite <= memWrite;
			pwdata <= memWdata;
		end
		if (memDone)
			rdataQ <= prdata;
	end

endmodule

// ==== logic/dzCore.sv ====
`timescale 1ns/1ps

module dzCore
#(
	parameter dzPkg::addrT resetPc = '0
)
(
	input  logic        iClock,
	input  logic        rstN,
	output logic        psel,
	output logic        penable,
	output logic        pwrite,
	output dzPkg::addrT paddr,
	output dzPkg::byteT pwdata,
	input  dzPkg::byteT prdata,
	input  logic        pready,
	output logic        halted
);
	import dzPkg::*;

	flowIdxT decFlow;
	flowIdxT uPc;
	uopT     uop;
	byteT    opLatch;
	logic    memReq;
	logic    memWrite;
	logic    memSel;
	logic    memDone;
	logic    exec;
	logic    zeroFlag;
	addrT    memAddr;
	byteT    memWdata;
	byteT    memRdata;

	ucodeDecode decode_i
	(
		.opcode  (opLatch),
		.flowIdx (decFlow)
	);

	ucodeRom rom_i
	(
		.flowIdx (uPc),
		.uop     (uop)
	);

	ucodeSequencer seq_i
	(
		.iClock   (iClock),
		.rstN     (rstN),
		.flowIdx  (decFlow),
		.uop      (uop),
		.zeroFlag (zeroFlag),
		.memDone  (memDone),
		.memRdata (memRdata),
		.memReq   (memReq),
		.memWrite (memWrite),
		.memSel   (memSel),
		.exec     (exec),
		.uPc      (uPc),
		.opLatch  (opLatch),
		.halted   (halted)
	);

	dzDatapath #(.resetPc(resetPc)) datapath_i
	(
		.iClock     (iClock),
		.rstN       (rstN),
		.exec       (exec),
		.uopAct     (uop.act),
		.uopOperand (uop.operand),
		.memDone    (memDone),
		.memSel     (memSel),
		.memRdata   (memRdata),
		.zeroFlag   (zeroFlag),
		.memAddr    (memAddr),
		.memWdata   (memWdata)
	);

	apbMaster apb_i
	(
		.iClock   (iClock),
		.rstN     (rstN),
		.memReq   (memReq),
		.memWrite (memWrite),
		.memAddr  (memAddr),
		.memWdata (memWdata),
		.memDone  (memDone),
		.memRdata (memRdata),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready)
	);

endmodule

// ==== logic/dzDatapath.sv ====
`timescale 1ns/1ps

module dzDatapath
#(
	parameter dzPkg::addrT resetPc = '0
)
(
	input  logic          iClock,
	input  logic          rstN,
	input  logic          exec,
	input  dzPkg::uopActT uopAct,
	input  dzPkg::regSelT uopOperand,
	input  logic          memDone,
	input  logic          memSel,
	input  dzPkg::byteT   memRdata,
	output logic          zeroFlag,
	output dzPkg::addrT   memAddr,
	output dzPkg::byteT   memWdata
);
	import dzPkg::*;

	// A, B, C, D, E, H, L in operand code order
	byteT       regs [0:6];
	addrT       pc;
	byteT       tmp;
	byteT       opVal;
	byteT       aluOut;
	logic [2:0] regIdx;

	assign regIdx = uopOperand[2:0];

	always_comb
	begin
		opVal = tmp;
		if (uopOperand <= regL)
			opVal = regs[regIdx];
	end

	////////////////////
	// 8 bit ALU without carry
	////////////////////
	always_comb
	begin
		case (uopAct)
			actInc:  aluOut = opVal + 8'd1;
			actDec:  aluOut = opVal - 8'd1;
			actAdd:  aluOut = regs[3'(regA)] + opVal;
			actSub:  aluOut = regs[3'(regA)] - opVal;
			default: aluOut = opVal;
		endcase
	end

	assign memAddr  = memSel ? {regs[3'(regH)], regs[3'(regL)]} : pc;
	assign memWdata = opVal;

	always_ff @(posedge iClock)
	begin
		if (!rstN)
		begin
			pc       <= resetPc;
			zeroFlag <= 1'b0;
			regs     <= '{default: '0};
		end
		else if (exec)
		begin
			case (uopAct)
				actLoadImm:
					regs[regIdx] <= tmp;
				actInc, actDec:
				begin
					regs[regIdx] <= aluOut;
					zeroFlag     <= aluOut == 8'd0;
				end
				actAdd, actSub:
				begin
					regs[3'(regA)] <= aluOut;
					zeroFlag       <= aluOut == 8'd0;
				end
				// Offset is relative to the byte after the operand
				actJumpRel:
					pc <= pc + {{8{tmp[7]}}, tmp};
				default:
					pc <= pc;
			endcase
		end
		else if (memDone)
		begin
			case (uopAct)
				actFetchOp, actReadOperand:
					pc <= pc + 16'd1;
				actLoadMem:
					regs[regIdx] <= memRdata;
				default:
					pc <= pc;
			endcase
		end
	end

	always_ff @(posedge iClock)
	begin
		if (memDone && uopAct == actReadOperand)
			tmp <= memRdata;
	end

endmodule

// ==== logic/dzPkg.sv ====
package dzPkg;

	typedef logic [7:0]  byteT;
	typedef logic [15:0] addrT;
	typedef logic [8:0]  flowIdxT;

	// Operand field
	// the first seven codes index the register file directly
	typedef enum logic [3:0]
	{
		regA, regB, regC, regD, regE, regH, regL,
		regHl, regPc, regTmp, regNone
	} regSelT;

	// When a flow stops
	typedef enum logic [1:0]
	{
		endNo, endYes, endIfZ, endHalt
	} uopEndT;

	// What a micro-op does
	typedef enum logic [3:0]
	{
		actNop, actFetchOp, actReadOperand, actLoadImm,
		actStoreReg, actLoadMem, actInc, actDec,
		actAdd, actSub, actJumpRel
	} uopActT;

	typedef struct packed
	{
		uopEndT uEnd;
		uopActT act;
		regSelT operand;
	} uopT;

	typedef enum logic [2:0]
	{
		stFetch, stWaitOp, stExec, stWaitMem, stHalt
	} seqStateT;

	////////////////////
	// Flow start indices
	////////////////////
	localparam flowIdxT flowFetch = 9'd0;
	localparam flowIdxT flowNop   = 9'd1;
	localparam flowIdxT flowHalt  = 9'd2;
	localparam flowIdxT flowJr    = 9'd3;
	localparam flowIdxT flowJrNz  = 9'd5;
	// Two entries per register
	localparam flowIdxT flowLdImm = 9'd7;
	localparam flowIdxT flowInc   = 9'd21;
	localparam flowIdxT flowDec   = 9'd28;
	localparam flowIdxT flowAdd   = 9'd35;
	localparam flowIdxT flowSub   = 9'd42;
	localparam flowIdxT flowStore = 9'd49;
	localparam flowIdxT flowLoad  = 9'd56;

endpackage

// ==== logic/ucodeDecode.sv ====
`timescale 1ns/1ps

module ucodeDecode
(
	input  dzPkg::byteT    opcode,
	output dzPkg::flowIdxT flowIdx
);
	import dzPkg::*;

	logic [2:0] dst;
	logic [2:0] src;
	logic       dstHl;

	// Z80 register code to register file index, A first
	function automatic logic [2:0] regIndex(input logic [2:0] code);
		return (code == 3'd7) ? 3'd0 : code + 3'd1;
	endfunction

	assign dst   = regIndex(opcode[5:3]);
	assign src   = regIndex(opcode[2:0]);
	// Code 110 names (HL), which has no flow of its own here
	assign dstHl = opcode[5:3] == 3'b110;

	always_comb
	begin
		flowIdx = flowNop;
		casez (opcode)
			8'h18: flowIdx = flowJr;
			8'h20: flowIdx = flowJrNz;
			8'h76: flowIdx = flowHalt;
			8'b00???100:
				if (!dstHl)
					flowIdx = flowInc + flowIdxT'(dst);
			8'b00???101:
				if (!dstHl)
					flowIdx = flowDec + flowIdxT'(dst);
			8'b00???110:
				if (!dstHl)
					flowIdx = flowLdImm + flowIdxT'({dst, 1'b0});
			// HALT sits on the one overlap of these two groups
			8'b01110???: flowIdx = flowStore + flowIdxT'(src);
			8'b01???110: flowIdx = flowLoad + flowIdxT'(dst);
			8'b10000???: flowIdx = flowAdd + flowIdxT'(src);
			8'b10010???: flowIdx = flowSub + flowIdxT'(src);
			default: flowIdx = flowNop;
		endcase
		if (opcode[7:6] == 2'b10 && opcode[2:0] == 3'b110)
			flowIdx = flowNop;
	end

endmodule

// ==== logic/ucodeRom.sv ====
`timescale 1ns/1ps

module ucodeRom
(
	input  dzPkg::flowIdxT flowIdx,
	output dzPkg::uopT     uop
);
	import dzPkg::*;

	always_comb
	begin
		case (flowIdx)
			// Shared opcode fetch step
			flowFetch: uop = '{endNo, actFetchOp, regPc};
			flowNop:   uop = '{endYes, actNop, regNone};
			flowHalt:  uop = '{endHalt, actNop, regNone};

			////////////////////
			// Relative jumps
			////////////////////
			flowJr:    uop = '{endNo, actReadOperand, regTmp};
			// Taken only while Z is clear
			flowJrNz:  uop = '{endIfZ, actReadOperand, regTmp};
			flowJr + 9'd1, flowJrNz + 9'd1:
				uop = '{endYes, actJumpRel, regTmp};

			////////////////////
			// LD r,n
			////////////////////
			flowLdImm + 9'd0, flowLdImm + 9'd2, flowLdImm + 9'd4, flowLdImm + 9'd6,
			flowLdImm + 9'd8, flowLdImm + 9'd10, flowLdImm + 9'd12:
				uop = '{endNo, actReadOperand, regTmp};
			flowLdImm + 9'd1:  uop = '{endYes, actLoadImm, regA};
			flowLdImm + 9'd3:  uop = '{endYes, actLoadImm, regB};
			flowLdImm + 9'd5:  uop = '{endYes, actLoadImm, regC};
			flowLdImm + 9'd7:  uop = '{endYes, actLoadImm, regD};
			flowLdImm + 9'd9:  uop = '{endYes, actLoadImm, regE};
			flowLdImm + 9'd11: uop = '{endYes, actLoadImm, regH};
			flowLdImm + 9'd13: uop = '{endYes, actLoadImm, regL};

			// INC r
			flowInc + 9'd0: uop = '{endYes, actInc, regA};
			flowInc + 9'd1: uop = '{endYes, actInc, regB};
			flowInc + 9'd2: uop = '{endYes, actInc, regC};
			flowInc + 9'd3: uop = '{endYes, actInc, regD};
			flowInc + 9'd4: uop = '{endYes, actInc, regE};
			flowInc + 9'd5: uop = '{endYes, actInc, regH};
			flowInc + 9'd6: uop = '{endYes, actInc, regL};
			// DEC r
			flowDec + 9'd0: uop = '{endYes, actDec, regA};
			flowDec + 9'd1: uop = '{endYes, actDec, regB};
			flowDec + 9'd2: uop = '{endYes, actDec, regC};
			flowDec + 9'd3: uop = '{endYes, actDec, regD};
			flowDec + 9'd4: uop = '{endYes, actDec, regE};
			flowDec + 9'd5: uop = '{endYes, actDec, regH};
			flowDec + 9'd6: uop = '{endYes, actDec, regL};
			// ADD A,r
			flowAdd + 9'd0: uop = '{endYes, actAdd, regA};
			flowAdd + 9'd1: uop = '{endYes, actAdd, regB};
			flowAdd + 9'd2: uop = '{endYes, actAdd, regC};
			flowAdd + 9'd3: uop = '{endYes, actAdd, regD};
			flowAdd + 9'd4: uop = '{endYes, actAdd, regE};
			flowAdd + 9'd5: uop = '{endYes, actAdd, regH};
			flowAdd + 9'd6: uop = '{endYes, actAdd, regL};
			// SUB A,r
			flowSub + 9'd0: uop = '{endYes, actSub, regA};
			flowSub + 9'd1: uop = '{endYes, actSub, regB};
			flowSub + 9'd2: uop = '{endYes, actSub, regC};
			flowSub + 9'd3: uop = '{endYes, actSub, regD};
			flowSub + 9'd4: uop = '{endYes, actSub, regE};
			flowSub + 9'd5: uop = '{endYes, actSub, regH};
			flowSub + 9'd6: uop = '{endYes, actSub, regL};

			////////////////////
			// Memory at HL
			////////////////////
			flowStore + 9'd0: uop = '{endYes, actStoreReg, regA};
			flowStore + 9'd1: uop = '{endYes, actStoreReg, regB};
			flowStore + 9'd2: uop = '{endYes, actStoreReg, regC};
			flowStore + 9'd3: uop = '{endYes, actStoreReg, regD};
			flowStore + 9'd4: uop = '{endYes, actStoreReg, regE};
			flowStore + 9'd5: uop = '{endYes, actStoreReg, regH};
			flowStore + 9'd6: uop = '{endYes, actStoreReg, regL};
			flowLoad + 9'd0:  uop = '{endYes, actLoadMem, regA};
			flowLoad + 9'd1:  uop = '{endYes, actLoadMem, regB};
			flowLoad + 9'd2:  uop = '{endYes, actLoadMem, regC};
			flowLoad + 9'd3:  uop = '{endYes, actLoadMem, regD};
			flowLoad + 9'd4:  uop = '{endYes, actLoadMem, regE};
			flowLoad + 9'd5:  uop = '{endYes, actLoadMem, regH};
			flowLoad + 9'd6:  uop = '{endYes, actLoadMem, regL};
			default: uop = '{endYes, actNop, regNone};
		endcase
	end

endmodule

// ==== logic/ucodeSequencer.sv ====
`timescale 1ns/1ps

module ucodeSequencer
(
	input  logic           iClock,
	input  logic           rstN,
	input  dzPkg::flowIdxT flowIdx,
	input  dzPkg::uopT     uop,
	input  logic           zeroFlag,
	input  logic           memDone,
	input  dzPkg::byteT    memRdata,
	output logic           memReq,
	output logic           memWrite,
	output logic           memSel,
	output logic           exec,
	output dzPkg::flowIdxT uPc,
	output dzPkg::byteT    opLatch,
	output logic           halted
);
	import dzPkg::*;

	seqStateT state;
	flowIdxT  uPcQ;
	flowIdxT  stepUPc;
	seqStateT stepState;
	logic     newFlow;
	logic     isMem;

	// First micro-op of a flow comes straight from the decoder
	assign uPc = newFlow ? flowIdx : uPcQ;

	assign isMem = (uop.act == actReadOperand) || (uop.act == actStoreReg) ||
		(uop.act == actLoadMem);
	assign memReq   = (state == stFetch) || (state == stExec && isMem);
	assign memWrite = uop.act == actStoreReg;
	assign memSel   = (uop.act == actStoreReg) || (uop.act == actLoadMem);
	assign exec     = (state == stExec) && !isMem;
	assign halted   = state == stHalt;

	// Where the flow goes once the current micro-op has completed
	always_comb
	begin
		stepState = stExec;
		stepUPc   = uPc + flowIdxT'(1);
		if (uop.uEnd == endHalt)
		begin
			stepState = stHalt;
			stepUPc   = uPc;
		end
		else if (uop.uEnd == endYes || (uop.uEnd == endIfZ && zeroFlag))
		begin
			stepState = stFetch;
			stepUPc   = flowFetch;
		end
	end

	always_ff @(posedge iClock)
	begin
		if (!rstN)
		begin
			state   <= stFetch;
			uPcQ    <= flowFetch;
			newFlow <= 1'b0;
		end
		else
		begin
			case (state)
				stFetch:
					state <= stWaitOp;
				stWaitOp:
					if (memDone)
					begin
						newFlow <= 1'b1;
						state   <= stExec;
					end
				stExec:
				begin
					newFlow <= 1'b0;
					if (isMem)
					begin
						// Hold the micro-op until the bus answers
						state <= stWaitMem;
						uPcQ  <= uPc;
					end
					else
					begin
						state <= stepState;
						uPcQ  <= stepUPc;
					end
				end
				stWaitMem:
					if (memDone)
					begin
						state <= stepState;
						uPcQ  <= stepUPc;
					end
				stHalt:
					state <= stHalt;
				default:
					state <= stFetch;
			endcase
		end
	end

	always_ff @(posedge iClock)
	begin
		if (state == stWaitOp && memDone)
			opLatch <= memRdata;
	end

endmodule

// ==== run.sh ====
#!/bin/bash
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module dzCoreTb -o dzCoreSim \
	|| { echo "Build failed"; exit 1; }
./obj_dir/dzCoreSim > sim.log 2>&1 \
	|| { cat sim.log; echo "Simulation exited with an error"; exit 1; }
cat sim.log
grep -qF "** FAIL **" sim.log && { echo "Test failed"; exit 1; } \
	|| { grep -qF "** PASS **" sim.log && echo "Test passed"; }

// ==== test/dzCoreTb.sv ====
`timescale 1ns/1ps

module dzCoreTb;
	import dzPkg::*;

	localparam addrT startPc  = 16'h0100;
	localparam int   maxWait  = 3;
	localparam int   maxSteps = 1000;
	// Opcode and operand transfers at worst wait, plus the exec cycles
	localparam int   instrCycles = 2 * (maxWait + 3) + 2;
	// Reset, the quiet check after HALT and some slack
	localparam int   extraCycles = 100;

	logic        iClock = 1'b0;
	logic        rstN = 1'b0;
	logic        psel;
	logic        penable;
	logic        pwrite;
	addrT        paddr;
	byteT        pwdata;
	byteT        prdata = 8'h00;
	logic        pready = 1'b0;
	logic        halted;

	byteT        mem [0:65535];
	byteT        refMem [0:65535];
	byteT        progBytes [$];
	addrT        expAddr [$];
	byteT        expData [$];
	int          mismatchCount = 0;
	int          otherCount = 0;
	int          writeIdx = 0;
	int          cycleCount = 0;
	int          cycleLimit = 0;
	int          refSteps;
	int          waitLeft = 0;
	int          i;
	logic [31:0] rngState = 32'h2261_01af;

	dzCore #(.resetPc(startPc)) dut_i
	(
		.iClock  (iClock),
		.rstN    (rstN),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.halted  (halted)
	);

	always #50 iClock = ~iClock;

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	////////////////////
	// Reference interpreter
	////////////////////

	// Registers by Z80 code with A at 7
	// Step count up to HALT or -1 without one
	function automatic int runReference();
		byteT       r [0:7];
		addrT       pcR;
		addrT       hl;
		byteT       op;
		byteT       imm;
		logic [2:0] dst;
		logic [2:0] src;
		logic       zf;
		logic       stop;
		int         steps;

		r     = '{default: 8'h00};
		pcR   = startPc;
		zf    = 1'b0;
		stop  = 1'b0;
		steps = 0;
		while (!stop && steps < maxSteps)
		begin
			op    = refMem[pcR];
			pcR   = pcR + 16'd1;
			dst   = op[5:3];
			src   = op[2:0];
			hl    = {r[4], r[5]};
			steps = steps + 1;
			if (op == 8'h76)
				stop = 1'b1;
			else if (op == 8'h18 || op == 8'h20)
			begin
				imm = refMem[pcR];
				pcR = pcR + 16'd1;
				// Offset counts from the byte after the operand
				if (op == 8'h18 || !zf)
					pcR = addrT'(int'(pcR) + int'($signed(imm)));
			end
			else if (op[7:6] == 2'b00 && dst != 3'd6 && src == 3'd6)
			begin
				r[dst] = refMem[pcR];
				pcR    = pcR + 16'd1;
			end
			else if (op[7:6] == 2'b00 && dst != 3'd6 && src[2:1] == 2'b10)
			begin
				r[dst] = src[0] ? r[dst] - 8'd1 : r[dst] + 8'd1;
				zf     = r[dst] == 8'h00;
			end
			else if (op[7:3] == 5'b01110)
			begin
				refMem[hl] = r[src];
				expAddr.push_back(hl);
				expData.push_back(r[src]);
			end
			else if (op[7:6] == 2'b01 && src == 3'd6)
				r[dst] = refMem[hl];
			else if (op[7:6] == 2'b10 && src != 3'd6 && (dst == 3'd0 || dst == 3'd2))
			begin
				r[7] = (dst == 3'd0) ? r[7] + r[src] : r[7] - r[src];
				zf   = r[7] == 8'h00;
			end
			// Anything else is a one byte NOP
		end
		return stop ? steps : -1;
	endfunction

	task automatic finishRun();
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	////////////////////
	// APB slave memory
	////////////////////
	always @(posedge iClock)
	begin
		if (!rstN)
			pready <= 1'b0;
		else if (psel && !penable)
		begin
			// New wait count per transfer
			rngState = lcgNext(rngState);
			waitLeft = int'(rngState[23:16]) % (maxWait + 1);
			pready <= waitLeft == 0;
			prdata <= mem[paddr];
		end
		else if (psel && penable)
		begin
			if (pready)
			begin
				if (pwrite)
					mem[paddr] <= pwdata;
				pready <= 1'b0;
			end
			else
			begin
				waitLeft = waitLeft - 1;
				pready <= waitLeft == 0;
			end
		end
	end

	// Completed writes checked mid cycle against the expected list
	always @(negedge iClock)
	begin
		if (rstN && psel && penable && pready && pwrite)
		begin
			if (writeIdx >= expAddr.size())
			begin
				$display("Unexpected extra write at %0t to address %h", $time, paddr);
				otherCount = otherCount + 1;
			end
			else
			begin
				if (paddr !== expAddr[writeIdx])
				begin
					$display("Mismatch at %0t: paddr expected %h, actual %h",
						$time, expAddr[writeIdx], paddr);
					mismatchCount = mismatchCount + 1;
				end
				if (pwdata !== expData[writeIdx])
				begin
					$display("Mismatch at %0t: pwdata expected %h, actual %h",
						$time, expData[writeIdx], pwdata);
					mismatchCount = mismatchCount + 1;
				end
			end
			writeIdx = writeIdx + 1;
		end
	end

	always @(posedge iClock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout after %0d cycles, the core did not halt in time", cycleCount);
			otherCount = otherCount + 1;
			finishRun();
		end
	end

	initial
	begin
		// Background bytes vary with both address halves
		for (i = 0; i < 65536; i = i + 1)
			mem[addrT'(i)] = byteT'(i ^ (i >> 8));
		mem[16'h9000] = 8'hA5;

		progBytes = '{
			// LD r,n then LD (HL),r for each register
			8'h26, 8'h80, 8'h74, 8'h2E, 8'h00, 8'h75,
			8'h3E, 8'h11, 8'h77, 8'h06, 8'h22, 8'h70,
			8'h0E, 8'h33, 8'h71, 8'h16, 8'h44, 8'h72,
			8'h1E, 8'h55, 8'h73,
			// INC and DEC across the wrap
			8'h3E, 8'hFF, 8'h3C, 8'h77, 8'h06, 8'h00, 8'h05, 8'h70,
			8'h0C, 8'h71, 8'h1D, 8'h73,
			// ADD and SUB on A
			8'h80, 8'h77, 8'h81, 8'h77, 8'h92, 8'h77, 8'h97, 8'h77,
			8'h3E, 8'h90, 8'h87, 8'h77,
			// JR over two stores, then a DEC loop on B
			8'h18, 8'h02, 8'h70, 8'h71, 8'h72,
			8'h06, 8'h03, 8'h70, 8'h05, 8'h20, 8'hFC,
			// Taken JR NZ after a nonzero DEC
			8'h0E, 8'h05, 8'h0D, 8'h20, 8'h01, 8'h71, 8'h73,
			// Loads through HL, then unknown opcodes
			8'h26, 8'h90, 8'h2E, 8'h00, 8'h56, 8'h2E, 8'h10, 8'h72,
			8'h2E, 8'h01, 8'h7E, 8'h77,
			8'h00, 8'h41, 8'h86, 8'hCB, 8'h34, 8'hFF, 8'h72, 8'h77,
			// HALT, and a store that must never run
			8'h76, 8'h70
		};
		for (i = 0; i < progBytes.size(); i = i + 1)
			mem[startPc + addrT'(i)] = progBytes[i];

		refMem   = mem;
		refSteps = runReference();
		if (refSteps < 0)
		begin
			$display("Reference program never reached HALT");
			otherCount = otherCount + 1;
			refSteps   = maxSteps;
		end
		cycleLimit = refSteps * instrCycles + extraCycles;

		repeat (5) @(posedge iClock);
		rstN <= 1'b1;
		@(negedge iClock);
		if (halted !== 1'b0)
		begin
			$display("halted is high right after reset");
			otherCount = otherCount + 1;
		end

		// Run until the core stops
		while (halted !== 1'b1)
			@(negedge iClock);

		repeat (20)
		begin
			@(negedge iClock);
			if (psel !== 1'b0)
			begin
				$display("An APB transfer started after HALT at %0t", $time);
				otherCount = otherCount + 1;
			end
			if (halted !== 1'b1)
			begin
				$display("halted dropped after HALT at %0t", $time);
				otherCount = otherCount + 1;
			end
		end

		if (writeIdx != expAddr.size())
		begin
			$display("Saw %0d writes, expected %0d", writeIdx, expAddr.size());
			otherCount = otherCount + 1;
		end
		finishRun();
	end

endmodule

// ==== test/dzCore_checker.sv ====
`timescale 1ns/1ps

module dzCore_checker
(
	input logic        iClock,
	input logic        rstN,
	input logic        psel,
	input logic        penable,
	input dzPkg::addrT paddr,
	input logic        pready,
	input logic        halted
);

	////////////////////
	// APB phases
	////////////////////

	// Setup lasts exactly one cycle
	assert property (@(posedge iClock) disable iff (!rstN)
		$rose(psel) |=> $rose(penable))
		else $error("penable did not rise one cycle after psel");

	assert property (@(posedge iClock) disable iff (!rstN)
		$rose(penable) |-> psel && $past(psel) && !$past(penable))
		else $error("penable rose without a setup phase");

	// Address held until the slave is ready
	assert property (@(posedge iClock) disable iff (!rstN)
		psel && !(penable && pready) |=> $stable(paddr))
		else $error("paddr changed during a transfer");

	assert property (@(posedge iClock)
		!rstN |=> !psel && !penable)
		else $error("APB select or enable high during reset");

	// Core stays stopped and quiet
	assert property (@(posedge iClock) disable iff (!rstN)
		halted |=> halted && !psel)
		else $error("core left the halted state or used the bus");

endmodule

bind dzCore dzCore_checker checker_i
(
	.iClock  (iClock),
	.rstN    (rstN),
	.psel    (psel),
	.penable (penable),
	.paddr   (paddr),
	.pready  (pready),
	.halted  (halted)
);
